// ==== verilog.f ====
+incdir+.
fpga_boot_pkg.sv
sync_chain.sv
icap_iprog_seq.sv
qspi_pin_stage.sv
fpga_boot_top.sv
fpga_boot_chk.sv
tb_fpga_boot.sv

// ==== tb_fpga_boot.sv ====
// single clock testbench; expected start latency is SYNC_STAGES + 1 edges, words per run fixed at 6
`timescale 1ns/1ps
`include "fpga_boot_cfg.svh"

module tb_fpga_boot;

    localparam int WORDS_PER_RUN = 6;
    localparam int BYTES_PER_WORD = `ICAP_WORD_W / `ICAP_BYTE_W;

    logic                       clk_125mhz_int;
    logic                       rst_n;
    logic                       boot_req;
    logic                       icap_avail;
    fpga_boot_pkg::qspi_out_t   qspi_ctrl;
    fpga_boot_pkg::qspi_dq_t    qspi_dq_pin;
    fpga_boot_pkg::icap_port_t  icap;
    fpga_boot_pkg::qspi_out_t   qspi_pins;
    fpga_boot_pkg::qspi_dq_t    qspi_dq_in;

    int mismatch_count = 0;
    int timeout_count = 0;

    // comparator state
    int step = 0;
    int seq_done = 0;
    int live_edges = 0;
    fpga_boot_pkg::qspi_out_t ctrl_d1;
    fpga_boot_pkg::qspi_dq_t  dq_d1;
    fpga_boot_pkg::qspi_dq_t  dq_d2;

    fpga_boot_top dut_i (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n          (rst_n),
        .boot_req       (boot_req),
        .icap_avail     (icap_avail),
        .qspi_ctrl      (qspi_ctrl),
        .qspi_dq_pin    (qspi_dq_pin),
        .icap           (icap),
        .qspi_pins      (qspi_pins),
        .qspi_dq_in     (qspi_dq_in)
    );

    // 125 MHz
    initial begin
        clk_125mhz_int = 1'b0;
        forever begin
            #4 clk_125mhz_int = ~clk_125mhz_int;
        end
    end

    // expected word for step 0..5, each byte mirrored
    function automatic fpga_boot_pkg::icap_word_t expected_word(input int idx);
        fpga_boot_pkg::icap_word_t raw;
        fpga_boot_pkg::icap_word_t mirrored;
        logic [`ICAP_BYTE_W-1:0]   one_byte;
        case (idx)
            0: raw = `ICAP_DUMMY_WORD;
            1: raw = `ICAP_SYNC_WORD;
            2: raw = `ICAP_NOOP_WORD;
            3: raw = `ICAP_CMD_WRITE_WORD;
            4: raw = `ICAP_IPROG_WORD;
            default: raw = `ICAP_NOOP_WORD;
        endcase
        mirrored = '0;
        for (int n = 0; n < BYTES_PER_WORD; n++) begin
            one_byte = raw[n*`ICAP_BYTE_W +: `ICAP_BYTE_W];
            for (int k = 0; k < `ICAP_BYTE_W; k++) begin
                mirrored[n*`ICAP_BYTE_W + k] = one_byte[`ICAP_BYTE_W-1-k];
            end
        end
        return mirrored;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    // counts falling edges until csib reaches level
    task automatic wait_for_csib(input logic level, input int limit, output int edges);
        bit seen;
        seen = 1'b0;
        edges = 0;
        while (!seen && edges < limit) begin
            @(negedge clk_125mhz_int);
            edges++;
            if (icap.csib === level) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("timeout: csib did not become %0b within %0d cycles", level, limit);
            timeout_count++;
        end
    endtask

    task automatic wait_for_seq(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (seq_done < target && cycles < limit) begin
            @(negedge clk_125mhz_int);
            cycles++;
        end
        if (seq_done < target) begin
            $display("timeout: only %0d of %0d sequences finished within %0d cycles",
                     seq_done, target, limit);
            timeout_count++;
        end
    endtask

    // port must stay deselected for quiet cycles in a row
    task automatic wait_idle(input int quiet, input int limit);
        int cycles;
        int run;
        cycles = 0;
        run = 0;
        while (run < quiet && cycles < limit) begin
            @(negedge clk_125mhz_int);
            cycles++;
            run = icap.csib ? run + 1 : 0;
        end
        if (run < quiet) begin
            $display("timeout: configuration port never went idle within %0d cycles", limit);
            timeout_count++;
        end
    endtask

    task automatic drive_random_flash(input int cycles);
        logic [31:0] r;
        repeat (cycles) begin
            @(negedge clk_125mhz_int);
            r = $urandom;
            qspi_ctrl = r[$bits(fpga_boot_pkg::qspi_out_t)-1:0];
            r = $urandom;
            qspi_dq_pin = r[`QSPI_DQ_W-1:0];
        end
    endtask

    // outputs are read before the edge updates them
    always @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            step = 0;
            live_edges = 0;
        end else begin
            check_value("rdwrb", icap.rdwrb, 1'b0);
            if (!icap.csib) begin
                if (step < WORDS_PER_RUN) begin
                    check_value("icap word", icap.data, expected_word(step));
                end else begin
                    check_value("csib low cycles", step + 1, WORDS_PER_RUN);
                end
                step++;
            end else if (step != 0) begin
                check_value("words in sequence", step, WORDS_PER_RUN);
                seq_done++;
                step = 0;
            end
            if (live_edges >= 1) begin
                check_value("qspi_pins", qspi_pins, ctrl_d1);
            end
            if (live_edges >= 2) begin
                check_value("qspi_dq_in", qspi_dq_in, dq_d2);
            end
            live_edges++;
        end
        dq_d2 = dq_d1;
        dq_d1 = qspi_dq_pin;
        ctrl_d1 = qspi_ctrl;
    end

    initial begin
        int edges;
        int base;
        int assert_total;
        void'($urandom(32'h3d86));
        rst_n = 1'b0;
        boot_req = 1'b0;
        icap_avail = 1'b0;
        qspi_ctrl.sclk = 1'b0;
        qspi_ctrl.cs = 1'b1;
        qspi_ctrl.dq_o = '0;
        qspi_ctrl.dq_oe = '0;
        qspi_dq_pin = '0;

        repeat (2) @(posedge clk_125mhz_int);
        @(negedge clk_125mhz_int);
        check_value("reset csib", icap.csib, 1'b1);
        check_value("reset icap data", icap.data, 32'hFFFFFFFF);
        check_value("reset qspi cs", qspi_pins.cs, 1'b1);
        check_value("reset qspi dq_oe", qspi_pins.dq_oe, '0);
        check_value("reset qspi sclk", qspi_pins.sclk, 1'b0);
        rst_n = 1'b1;

        // full sequence, request dropped once the port is selected
        @(negedge clk_125mhz_int);
        icap_avail = 1'b1;
        @(negedge clk_125mhz_int);
        base = seq_done;
        boot_req = 1'b1;
        wait_for_csib(1'b0, 20, edges);
        check_value("edges to csib fall", edges, `SYNC_STAGES + 1);
        boot_req = 1'b0;
        wait_for_csib(1'b1, 20, edges);
        check_value("csib low length", edges, WORDS_PER_RUN);
        wait_for_seq(base + 1, 10);
        repeat (12) @(negedge clk_125mhz_int);
        check_value("single run count", seq_done - base, 1);
        check_value("csib after single run", icap.csib, 1'b1);

        // start held off while the port is busy
        base = seq_done;
        icap_avail = 1'b0;
        boot_req = 1'b1;
        repeat (20) begin
            @(negedge clk_125mhz_int);
            check_value("csib while blocked", icap.csib, 1'b1);
        end
        icap_avail = 1'b1;
        wait_for_csib(1'b0, 10, edges);
        check_value("edges after avail", edges, 1);
        // a running sequence finishes regardless
        icap_avail = 1'b0;
        boot_req = 1'b0;
        wait_for_csib(1'b1, 20, edges);
        check_value("csib low after avail drop", edges, WORDS_PER_RUN);
        wait_for_seq(base + 1, 10);

        // back-to-back runs with one deselected cycle between them
        wait_idle(4, 20);
        base = seq_done;
        icap_avail = 1'b1;
        boot_req = 1'b1;
        wait_for_csib(1'b0, 20, edges);
        for (int run = 0; run < 3; run++) begin
            if (run > 0) begin
                wait_for_csib(1'b0, 10, edges);
                check_value("gap between runs", edges, 1);
            end
            wait_for_csib(1'b1, 20, edges);
            check_value("repeat csib low length", edges, WORDS_PER_RUN);
        end
        // request still sits in the synchronizer, so a fourth run follows
        boot_req = 1'b0;
        wait_idle(8, 40);
        wait_for_seq(base + 4, 10);
        check_value("repeat runs seen", seq_done - base, 4);

        // flash pins and data input with random traffic
        icap_avail = 1'b0;
        drive_random_flash(200);
        repeat (3) @(negedge clk_125mhz_int);

        assert_total = dut_i.chk_i.assert_fails;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count, assert_total);
        if (mismatch_count == 0 && timeout_count == 0 && assert_total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== fpga_boot_chk.sv ====
// checks assume rst_n is synchronous; all properties are disabled while rst_n is low
`timescale 1ns/1ps

module fpga_boot_chk (
    input logic                       clk_125mhz_int,
    input logic                       rst_n,
    input logic                       icap_avail,
    input fpga_boot_pkg::icap_port_t  icap,
    input fpga_boot_pkg::qspi_out_t   qspi_ctrl,
    input fpga_boot_pkg::qspi_out_t   qspi_pins,
    input fpga_boot_pkg::icap_state_t seq_state
);

    // read back by the testbench for its closing summary
    int assert_fails = 0;

    // configuration port is write only
    rdwrb_low_a: assert property (
        @(posedge clk_125mhz_int) disable iff (!rst_n)
        !icap.rdwrb
    ) else begin
        assert_fails++;
        $error("rdwrb went high");
    end

    // one IPROG sequence keeps the port selected for six words
    csib_window_a: assert property (
        @(posedge clk_125mhz_int) disable iff (!rst_n)
        $fell(icap.csib) |-> (!icap.csib) [*6] ##1 icap.csib
    ) else begin
        assert_fails++;
        $error("csib low window is not six cycles");
    end

    // a run starts only from IDLE and only with the port available
    start_from_idle_a: assert property (
        @(posedge clk_125mhz_int) disable iff (!rst_n)
        $fell(icap.csib) |->
            ($past(seq_state) == fpga_boot_pkg::IDLE) && $past(icap_avail)
    ) else begin
        assert_fails++;
        $error("sequence started outside IDLE or with the port unavailable");
    end

    // flash pins are the controller outputs one cycle late
    pins_delay_a: assert property (
        @(posedge clk_125mhz_int) disable iff (!rst_n)
        $past(rst_n) |-> qspi_pins == $past(qspi_ctrl)
    ) else begin
        assert_fails++;
        $error("qspi_pins differ from last cycle's qspi_ctrl");
    end

endmodule

bind fpga_boot_top fpga_boot_chk chk_i (
    .clk_125mhz_int (clk_125mhz_int),
    .rst_n          (rst_n),
    .icap_avail     (icap_avail),
    .icap           (icap),
    .qspi_ctrl      (qspi_ctrl),
    .qspi_pins      (qspi_pins),
    .seq_state      (iprog_seq_i.state_q)
);

// ==== fpga_boot_top.sv ====
// single clock domain, rst_n must already be synchronous to clk_125mhz_int; no vendor primitives
`timescale 1ns/1ps
`include "fpga_boot_cfg.svh"

module fpga_boot_top (
    input  logic                     clk_125mhz_int,
    input  logic                     rst_n,

    // reboot request from the core, asynchronous level
    input  logic                     boot_req,
    // configuration port status
    input  logic                     icap_avail,

    // flash controller side
    input  fpga_boot_pkg::qspi_out_t qspi_ctrl,
    input  fpga_boot_pkg::qspi_dq_t  qspi_dq_pin,

    // to the configuration port
    output fpga_boot_pkg::icap_port_t icap,

    // to the flash pins and back to the controller
    output fpga_boot_pkg::qspi_out_t qspi_pins,
    output fpga_boot_pkg::qspi_dq_t  qspi_dq_in
);

    logic boot_req_sync;

    // boot request synchronizer
    sync_chain #(
        .payload_t (logic),
        .STAGES    (`SYNC_STAGES)
    ) boot_sync_i (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n          (rst_n),
        .din            (boot_req),
        .dout           (boot_req_sync)
    );

    // IPROG command sequencer
    icap_iprog_seq iprog_seq_i (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n          (rst_n),
        .boot_req_sync  (boot_req_sync),
        .icap_avail     (icap_avail),
        .icap           (icap)
    );

    // flash pin registers and data input sync
    qspi_pin_stage qspi_stage_i (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n          (rst_n),
        .qspi_ctrl      (qspi_ctrl),
        .qspi_dq_pin    (qspi_dq_pin),
        .qspi_pins      (qspi_pins),
        .qspi_dq_in     (qspi_dq_in)
    );

endmodule

// ==== qspi_pin_stage.sv ====
// outputs add one cycle of latency, dq input adds SYNC_STAGES cycles; no tristate buffers here
`timescale 1ns/1ps
`include "fpga_boot_cfg.svh"

module qspi_pin_stage (
    input  logic                    clk_125mhz_int,
    input  logic                    rst_n,
    input  fpga_boot_pkg::qspi_out_t qspi_ctrl,
    input  fpga_boot_pkg::qspi_dq_t  qspi_dq_pin,
    output fpga_boot_pkg::qspi_out_t qspi_pins,
    output fpga_boot_pkg::qspi_dq_t  qspi_dq_in
);

    fpga_boot_pkg::qspi_out_t pins_q;

    // output register, reset leaves the flash deselected and undriven
    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            pins_q.sclk  <= 1'b0;
            pins_q.cs    <= 1'b1;
            pins_q.dq_o  <= '0;
            pins_q.dq_oe <= '0;
        end else begin
            pins_q.sclk  <= qspi_ctrl.sclk;
            pins_q.cs    <= qspi_ctrl.cs;
            pins_q.dq_o  <= qspi_ctrl.dq_o;
            pins_q.dq_oe <= qspi_ctrl.dq_oe;
        end
    end

    assign qspi_pins = pins_q;

    // flash data back into the clock domain
    sync_chain #(
        .payload_t (fpga_boot_pkg::qspi_dq_t),
        .STAGES    (`SYNC_STAGES)
    ) dq_sync_i (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n          (rst_n),
        .din            (qspi_dq_pin),
        .dout           (qspi_dq_in)
    );

endmodule

// ==== icap_iprog_seq.sv ====
// boot_req_sync must already be synchronous; a started sequence ignores icap_avail until done
`timescale 1ns/1ps
`include "fpga_boot_cfg.svh"

module icap_iprog_seq (
    input  logic                     clk_125mhz_int,
    input  logic                     rst_n,
    input  logic                     boot_req_sync,
    input  logic                     icap_avail,
    output fpga_boot_pkg::icap_port_t icap
);

    localparam int BYTE_W = `ICAP_BYTE_W;
    localparam int WORD_W = `ICAP_WORD_W;

    fpga_boot_pkg::icap_state_t state_q;
    fpga_boot_pkg::icap_word_t  word_q;
    logic                       csib_q;

    fpga_boot_pkg::icap_word_t  word_rev;

    // start only from a deselected port, so back-to-back runs get one
    // cycle with csib high in between
    logic start;

    assign start = boot_req_sync && icap_avail && csib_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            state_q <= fpga_boot_pkg::IDLE;
            csib_q  <= 1'b1;
            word_q  <= `ICAP_DUMMY_WORD;
        end else begin
            case (state_q)
                fpga_boot_pkg::IDLE: begin
                    // idle default, also ends the trailing no-op cycle
                    csib_q <= 1'b1;
                    word_q <= `ICAP_DUMMY_WORD;
                    if (start) begin
                        state_q <= fpga_boot_pkg::DUMMY;
                        csib_q  <= 1'b0;
                    end
                end
                fpga_boot_pkg::DUMMY: begin
                    state_q <= fpga_boot_pkg::SYNC;
                    csib_q  <= 1'b0;
                    word_q  <= `ICAP_SYNC_WORD;
                end
                fpga_boot_pkg::SYNC: begin
                    state_q <= fpga_boot_pkg::NOOP1;
                    csib_q  <= 1'b0;
                    word_q  <= `ICAP_NOOP_WORD;
                end
                fpga_boot_pkg::NOOP1: begin
                    state_q <= fpga_boot_pkg::CMD;
                    csib_q  <= 1'b0;
                    word_q  <= `ICAP_CMD_WRITE_WORD;
                end
                fpga_boot_pkg::CMD: begin
                    state_q <= fpga_boot_pkg::IPROG;
                    csib_q  <= 1'b0;
                    word_q  <= `ICAP_IPROG_WORD;
                end
                fpga_boot_pkg::IPROG: begin
                    // trailing no-op, csib stays low one more cycle in IDLE
                    state_q <= fpga_boot_pkg::IDLE;
                    csib_q  <= 1'b0;
                    word_q  <= `ICAP_NOOP_WORD;
                end
                default: begin
                    state_q <= fpga_boot_pkg::IDLE;
                    csib_q  <= 1'b1;
                    word_q  <= `ICAP_DUMMY_WORD;
                end
            endcase
        end
    end

    // config port wants each byte MSB-first on bit 0
    always_comb begin
        for (int i = 0; i < WORD_W; i++) begin
            word_rev[i] = word_q[(i / BYTE_W) * BYTE_W + (BYTE_W - 1 - (i % BYTE_W))];
        end
    end

    assign icap.csib  = csib_q;
    // write only, readback is not used
    assign icap.rdwrb = 1'b0;
    assign icap.data  = word_rev;

endmodule

// ==== sync_chain.sv ====
// plain flop chain with no metastability constraints attached; STAGES must be 2 or more
`timescale 1ns/1ps

module sync_chain #(
    parameter type payload_t = logic,
    parameter int  STAGES    = 2
) (
    input  logic     clk_125mhz_int,
    input  logic     rst_n,
    input  payload_t din,
    output payload_t dout
);

    // stage 0 takes the asynchronous input
    payload_t stage_q [STAGES];

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign dout = stage_q[STAGES-1];

endmodule

// ==== fpga_boot_pkg.sv ====
// shared types for the boot and flash path; widths come from fpga_boot_cfg.svh
`include "fpga_boot_cfg.svh"

package fpga_boot_pkg;

    // one configuration word
    typedef logic [`ICAP_WORD_W-1:0] icap_word_t;

    // sequencer states, named after the word sent while in that state
    // IPROG also loads the trailing no-op
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        DUMMY = 3'd1,
        SYNC  = 3'd2,
        NOOP1 = 3'd3,
        CMD   = 3'd4,
        IPROG = 3'd5
    } icap_state_t;

    // configuration port write side
    typedef struct packed {
        // active low select
        logic       csib;
        // low for write
        logic       rdwrb;
        // already bit reversed within each byte
        icap_word_t data;
    } icap_port_t;

    // flash data lines
    typedef logic [`QSPI_DQ_W-1:0] qspi_dq_t;

    // flash pin outputs from the controller
    typedef struct packed {
        logic     sclk;
        // high means deselected
        logic     cs;
        qspi_dq_t dq_o;
        // per line output enable
        qspi_dq_t dq_oe;
    } qspi_out_t;

endpackage

// ==== fpga_boot_cfg.svh ====
// command words follow the 7-series/UltraScale IPROG sequence; SYNC_STAGES must be 2 or more
`ifndef FPGA_BOOT_CFG_SVH
`define FPGA_BOOT_CFG_SVH

// configuration port command words, in natural bit order
`define ICAP_DUMMY_WORD      32'hFFFFFFFF
`define ICAP_SYNC_WORD       32'hAA995566
`define ICAP_NOOP_WORD       32'h20000000
`define ICAP_CMD_WRITE_WORD  32'h30008001
`define ICAP_IPROG_WORD      32'h0000000F

// width of one configuration word
`define ICAP_WORD_W          32

// bit reversal is applied within groups of this many bits
`define ICAP_BYTE_W          8

// flip-flops in each synchronizer chain
`define SYNC_STAGES          2

// flash data lines, quad mode
`define QSPI_DQ_W            4

`endif
